// ==== common/harness_pkg.sv ====
/*
 * Board harness shared definitions.
 * Pin indices, I2C bus and fault encodings, and the vector and struct types.
 */
package harness_pkg;

  // System output pins.
  typedef enum logic [1:0] {
    OUT_PIN_RS485_TX,
    OUT_PIN_MB4,
    OUT_PIN_MB7,
    OUT_PIN_MB10
  } out_pin_e;

  // System input pins.
  typedef enum logic [1:0] {
    IN_PIN_RS485_RX,
    IN_PIN_MB3,
    IN_PIN_MB8
  } in_pin_e;

  // Bidirectional pins.
  typedef enum logic [3:0] {
    INOUT_PIN_SCL0,
    INOUT_PIN_SDA0,
    INOUT_PIN_SCL1,
    INOUT_PIN_SDA1,
    INOUT_PIN_RPH_G0,
    INOUT_PIN_RPH_G1,
    INOUT_PIN_RPH_G2_SDA,
    INOUT_PIN_RPH_G3_SCL,
    INOUT_PIN_MB5,
    INOUT_PIN_MB6,
    INOUT_PIN_PMOD0_1,
    INOUT_PIN_AH_TMPIO0,
    INOUT_PIN_AH_TMPIO1,
    INOUT_PIN_AH_TMPIO8,
    INOUT_PIN_AH_TMPIO9
  } inout_pin_e;

  localparam int unsigned NumOutPins   = 4;
  localparam int unsigned NumInPins    = 3;
  localparam int unsigned NumInoutPins = 15;

  typedef logic [NumOutPins-1:0]   out_pins_t;
  typedef logic [NumInPins-1:0]    in_pins_t;
  typedef logic [NumInoutPins-1:0] inout_pins_t;

  // I2C buses that have a device on the far side.
  typedef enum logic [1:0] {
    I2C_BUS_RPI0,
    I2C_BUS_RPI1,
    I2C_BUS_QWIIC1
  } i2c_bus_e;

  localparam int unsigned NumI2cBuses = 3;

  // Controller side of one bus, value and enable per line.
  typedef struct packed {
    logic scl;
    logic scl_en;
    logic sda;
    logic sda_en;
  } i2c_drive_t;

  // Plain line levels of one bus.
  typedef struct packed {
    logic scl;
    logic sda;
  } i2c_lines_t;

  // CHERI fault classes, bit order of the fault vector.
  typedef enum logic [3:0] {
    FAULT_BOUNDS,
    FAULT_TAG,
    FAULT_SEAL,
    FAULT_PERMIT_EXECUTE,
    FAULT_PERMIT_LOAD,
    FAULT_PERMIT_STORE,
    FAULT_PERMIT_STORE_CAP,
    FAULT_PERMIT_STORE_LOCAL_CAP,
    FAULT_PERMIT_ACC_SYS_REGS
  } fault_e;

  localparam int unsigned NumFaults = 9;

  typedef logic [NumFaults-1:0] fault_vec_t;

endpackage

// ==== filelist.f ====
common/harness_pkg.sv
i2c/i2c_bus_resolve.sv
logic/pin_router.sv
logic/fault_latch.sv
logic/board_harness.sv
test/board_harness_asserts.sv
test/board_harness_tb.sv

// ==== i2c/i2c_bus_resolve.sv ====
/*
 * I2C bus resolver.
 * Open-drain resolution of each bus between controller and device.
 */
`timescale 1ns/10ps

module i2c_bus_resolve import harness_pkg::*; #(
  parameter int unsigned NumI2cBuses = harness_pkg::NumI2cBuses
) (
  input  i2c_drive_t [NumI2cBuses-1:0] drive_i,
  input  i2c_lines_t [NumI2cBuses-1:0] dev_i,
  output i2c_lines_t [NumI2cBuses-1:0] bus_o,
  output i2c_lines_t [NumI2cBuses-1:0] readback_o
);

  // Lines as driven out by the controller.
  i2c_lines_t [NumI2cBuses-1:0] out_lines;

  for (genvar b = 0; b < NumI2cBuses; b++) begin : g_bus
    // Released line floats up to the pull-up.
    assign out_lines[b].scl = drive_i[b].scl_en ? drive_i[b].scl : 1'b1;
    assign out_lines[b].sda = drive_i[b].sda_en ? drive_i[b].sda : 1'b1;

    // Wired-AND with the device side.
    // The controller sees clock stretching and ACKs here.
    assign readback_o[b].scl = out_lines[b].scl & dev_i[b].scl;
    assign readback_o[b].sda = out_lines[b].sda & dev_i[b].sda;
  end

  // Device sees the controller's side only.
  assign bus_o = out_lines;

endmodule

// ==== logic/board_harness.sv ====
/*
 * Board pin harness top level.
 * Joins the pin router, I2C resolver and CHERI fault latch.
 */
`timescale 1ns/10ps

module board_harness import harness_pkg::*; #(
  parameter int unsigned NumI2cBuses = harness_pkg::NumI2cBuses
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // System pin vectors.
  input  out_pins_t                     out_pins_i,
  input  inout_pins_t                   inout_to_i,
  input  inout_pins_t                   inout_en_i,
  output in_pins_t                      in_pins_o,
  output inout_pins_t                   inout_from_o,
  // RS485 transceiver.
  input  logic                          rs485_tx_en_i,
  input  logic                          rs485_rx_en_i,
  input  logic                          rs485_line_i,
  output logic                          rs485_line_o,
  // I2C device side.
  input  i2c_lines_t [NumI2cBuses-1:0]  i2c_dev_i,
  output i2c_lines_t [NumI2cBuses-1:0]  i2c_bus_o,
  // CHERI faults.
  input  fault_vec_t                    cheri_err_i,
  output fault_vec_t                    fault_seen_o,
  output logic                          new_fault_o,
  output fault_e                        first_fault_o
);

  i2c_drive_t [NumI2cBuses-1:0] i2c_drive;
  i2c_lines_t [NumI2cBuses-1:0] i2c_readback;

  // Pin side.
  pin_router #(
    .NumI2cBuses (NumI2cBuses)
  ) u_pin_router (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .out_pins_i     (out_pins_i),
    .inout_to_i     (inout_to_i),
    .inout_en_i     (inout_en_i),
    .rs485_tx_en_i  (rs485_tx_en_i),
    .rs485_rx_en_i  (rs485_rx_en_i),
    .rs485_line_i   (rs485_line_i),
    .rs485_line_o   (rs485_line_o),
    .i2c_drive_o    (i2c_drive),
    .i2c_readback_i (i2c_readback),
    .in_pins_o      (in_pins_o),
    .inout_from_o   (inout_from_o)
  );

  // Open-drain buses.
  i2c_bus_resolve #(
    .NumI2cBuses (NumI2cBuses)
  ) u_i2c_bus_resolve (
    .drive_i    (i2c_drive),
    .dev_i      (i2c_dev_i),
    .bus_o      (i2c_bus_o),
    .readback_o (i2c_readback)
  );

  // Fault reporting.
  fault_latch u_fault_latch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .err_i         (cheri_err_i),
    .seen_o        (fault_seen_o),
    .new_fault_o   (new_fault_o),
    .first_fault_o (first_fault_o)
  );

endmodule

// ==== logic/fault_latch.sv ====
/*
 * Sticky CHERI fault latch.
 * Remembers each fault class, pulses once on the first occurrence of a class
 * and names the lowest newly seen class.
 */
`timescale 1ns/10ps

module fault_latch import harness_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  fault_vec_t err_i,
  output fault_vec_t seen_o,
  output logic       new_fault_o,
  output fault_e     first_fault_o
);

  fault_vec_t seen_q;
  fault_vec_t fresh;
  logic       new_q;
  fault_e     first_q;

  // Lowest set class in a fault vector.
  function automatic fault_e lowest_fault(fault_vec_t v);
    fault_e f;
    f = FAULT_BOUNDS;
    for (int i = NumFaults - 1; i >= 0; i--) begin
      if (v[i]) begin
        f = fault_e'(i[3:0]);
      end
    end
    return f;
  endfunction

  // Classes not seen before.
  // Fault lines drive LEDs and are modulated, so repeats are normal.
  assign fresh = err_i & ~seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_q  <= '0;
      new_q   <= 1'b0;
      first_q <= FAULT_BOUNDS;
    end else begin
      seen_q <= seen_q | err_i;
      new_q  <= |fresh;
      // Hold the last name between pulses.
      if (|fresh) begin
        first_q <= lowest_fault(fresh);
      end
    end
  end

  assign seen_o        = seen_q;
  assign new_fault_o   = new_q;
  assign first_fault_o = first_q;

endmodule

// ==== logic/pin_router.sv ====
/*
 * Pin router.
 * Unpacks the system pin vectors into I2C bus drives, scatters read-back
 * lines, ties off unused pins, retimes loopbacks and gates the RS485 lines.
 */
`timescale 1ns/10ps

module pin_router import harness_pkg::*; #(
  parameter int unsigned NumI2cBuses = harness_pkg::NumI2cBuses
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  out_pins_t                     out_pins_i,
  input  inout_pins_t                   inout_to_i,
  input  inout_pins_t                   inout_en_i,
  input  logic                          rs485_tx_en_i,
  input  logic                          rs485_rx_en_i,
  input  logic                          rs485_line_i,
  output logic                          rs485_line_o,
  output i2c_drive_t [NumI2cBuses-1:0]  i2c_drive_o,
  input  i2c_lines_t [NumI2cBuses-1:0]  i2c_readback_i,
  output in_pins_t                      in_pins_o,
  output inout_pins_t                   inout_from_o
);

  // Loopback targets, one register stage.
  typedef struct packed {
    logic ah_tmpio9;
    logic ah_tmpio0;
    logic pmod0_1;
    logic mb8;
    logic mb3;
  } loopback_t;

  loopback_t loop_d;
  loopback_t loop_q;

  // SCL pin of each bus.
  function automatic inout_pin_e scl_pin(int unsigned bus);
    case (bus)
      I2C_BUS_RPI0:   return INOUT_PIN_RPH_G1;
      I2C_BUS_RPI1:   return INOUT_PIN_RPH_G3_SCL;
      I2C_BUS_QWIIC1: return INOUT_PIN_SCL1;
      default:        return INOUT_PIN_SCL0;
    endcase
  endfunction

  // SDA pin of each bus.
  function automatic inout_pin_e sda_pin(int unsigned bus);
    case (bus)
      I2C_BUS_RPI0:   return INOUT_PIN_RPH_G0;
      I2C_BUS_RPI1:   return INOUT_PIN_RPH_G2_SDA;
      I2C_BUS_QWIIC1: return INOUT_PIN_SDA1;
      default:        return INOUT_PIN_SDA0;
    endcase
  endfunction

  // Gather value and enable for each bus.
  for (genvar b = 0; b < NumI2cBuses; b++) begin : g_drive
    assign i2c_drive_o[b] = '{
      scl:    inout_to_i[scl_pin(b)],
      scl_en: inout_en_i[scl_pin(b)],
      sda:    inout_to_i[sda_pin(b)],
      sda_en: inout_en_i[sda_pin(b)]
    };
  end

  // Loopback sources.
  // PWM, UART and SPI loops from the mikroBUS, two GPIO loops on the Arduino header.
  assign loop_d = '{
    ah_tmpio9: inout_to_i[INOUT_PIN_AH_TMPIO8],
    ah_tmpio0: inout_to_i[INOUT_PIN_AH_TMPIO1],
    pmod0_1:   out_pins_i[OUT_PIN_MB10],
    mb8:       out_pins_i[OUT_PIN_MB7],
    mb3:       out_pins_i[OUT_PIN_MB4]
  };

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loop_q <= '0;
    end else begin
      loop_q <= loop_d;
    end
  end

  // Bidirectional pins back into the system.
  always_comb begin
    inout_from_o = '0;
    // Resolved I2C lines at their mapped pins.
    for (int unsigned b = 0; b < NumI2cBuses; b++) begin
      inout_from_o[scl_pin(b)] = i2c_readback_i[b].scl;
      inout_from_o[sda_pin(b)] = i2c_readback_i[b].sda;
    end
    // No device on these pins, only the board pull-ups.
    inout_from_o[INOUT_PIN_SCL0] = 1'b1;
    inout_from_o[INOUT_PIN_SDA0] = 1'b1;
    inout_from_o[INOUT_PIN_MB5]  = 1'b1;
    inout_from_o[INOUT_PIN_MB6]  = 1'b1;
    // Loopback targets.
    inout_from_o[INOUT_PIN_AH_TMPIO9] = loop_q.ah_tmpio9;
    inout_from_o[INOUT_PIN_AH_TMPIO0] = loop_q.ah_tmpio0;
    inout_from_o[INOUT_PIN_PMOD0_1]   = loop_q.pmod0_1;
  end

  // Input pins.
  always_comb begin
    in_pins_o = '0;
    // Receiver output is low while receive is off.
    in_pins_o[IN_PIN_RS485_RX] = rs485_rx_en_i ? rs485_line_i : 1'b0;
    in_pins_o[IN_PIN_MB3]      = loop_q.mb3;
    in_pins_o[IN_PIN_MB8]      = loop_q.mb8;
  end

  // Line idles high when the driver is off.
  assign rs485_line_o = rs485_tx_en_i ? out_pins_i[OUT_PIN_RS485_TX] : 1'b1;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the board harness testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module board_harness_tb -f filelist.f -o sim_board_harness

out=$(./obj_dir/sim_board_harness +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi

// ==== test/board_harness_asserts.sv ====
/*
 * Board harness checker.
 * Concurrent assertions on I2C resolution, tie-offs, loopback, RS485 gating
 * and the fault latch, with a running count of failures.
 */
`timescale 1ns/10ps

module board_harness_asserts import harness_pkg::*; #(
  parameter int unsigned NumI2cBuses = harness_pkg::NumI2cBuses
) (
  input logic                         clk_i,
  input logic                         rst_ni,
  input out_pins_t                    out_pins_i,
  input inout_pins_t                  inout_to_i,
  input inout_pins_t                  inout_en_i,
  input in_pins_t                     in_pins_o,
  input inout_pins_t                  inout_from_o,
  input logic                         rs485_tx_en_i,
  input logic                         rs485_rx_en_i,
  input logic                         rs485_line_i,
  input logic                         rs485_line_o,
  input i2c_lines_t [NumI2cBuses-1:0] i2c_dev_i,
  input i2c_lines_t [NumI2cBuses-1:0] i2c_bus_o,
  input fault_vec_t                   cheri_err_i,
  input fault_vec_t                   fault_seen_o,
  input logic                         new_fault_o,
  input fault_e                       first_fault_o
);

  // Board wiring of each bus in bus order RPI0, RPI1, QWIIC1.
  localparam inout_pin_e SclPin [3] = '{INOUT_PIN_RPH_G1, INOUT_PIN_RPH_G3_SCL, INOUT_PIN_SCL1};
  localparam inout_pin_e SdaPin [3] = '{INOUT_PIN_RPH_G0, INOUT_PIN_RPH_G2_SDA, INOUT_PIN_SDA1};

  int unsigned fail_count = 0;

  logic [4:0] loop_src;
  logic [4:0] loop_dst;
  logic [4:0] loop_src_q;
  fault_vec_t seen_ref;
  fault_vec_t fresh_ref;
  fault_vec_t lowest_ref;
  fault_vec_t fresh_q;
  fault_vec_t lowest_q;

  // Loopback pairs with source and target in the same bit.
  assign loop_src = {inout_to_i[INOUT_PIN_AH_TMPIO8], inout_to_i[INOUT_PIN_AH_TMPIO1],
                     out_pins_i[OUT_PIN_MB10], out_pins_i[OUT_PIN_MB7], out_pins_i[OUT_PIN_MB4]};
  assign loop_dst = {inout_from_o[INOUT_PIN_AH_TMPIO9], inout_from_o[INOUT_PIN_AH_TMPIO0],
                     inout_from_o[INOUT_PIN_PMOD0_1], in_pins_o[IN_PIN_MB8], in_pins_o[IN_PIN_MB3]};

  // Unseen classes and the lowest one isolated as a single bit.
  assign fresh_ref  = cheri_err_i & ~seen_ref;
  assign lowest_ref = fresh_ref & (~fresh_ref + 1'b1);

  // Reference state lags the inputs by one cycle.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_ref   <= '0;
      fresh_q    <= '0;
      lowest_q   <= '0;
      loop_src_q <= '0;
    end else begin
      seen_ref   <= seen_ref | cheri_err_i;
      fresh_q    <= fresh_ref;
      lowest_q   <= lowest_ref;
      loop_src_q <= loop_src;
    end
  end

  for (genvar b = 0; b < NumI2cBuses; b++) begin : g_bus
    i2c_lines_t exp_bus;
    // Released line reads as the pull-up.
    assign exp_bus.scl = inout_to_i[SclPin[b]] | !inout_en_i[SclPin[b]];
    assign exp_bus.sda = inout_to_i[SdaPin[b]] | !inout_en_i[SdaPin[b]];

    a_bus: assert property (@(posedge clk_i) i2c_bus_o[b] == exp_bus)
      else begin
        fail_count++;
        $error("error %0t i2c_bus_o[%0d] expected %b got %b", $time, b,
               $sampled(exp_bus), $sampled(i2c_bus_o[b]));
      end

    // Wired-AND of controller and device.
    a_readback: assert property (@(posedge clk_i)
        {inout_from_o[SclPin[b]], inout_from_o[SdaPin[b]]} == (exp_bus & i2c_dev_i[b]))
      else begin
        fail_count++;
        $error("error %0t inout_from_o bus %0d expected %b got %b", $time, b,
               $sampled(exp_bus & i2c_dev_i[b]),
               $sampled({inout_from_o[SclPin[b]], inout_from_o[SdaPin[b]]}));
      end
  end

  a_tie_off: assert property (@(posedge clk_i)
      {inout_from_o[INOUT_PIN_SCL0], inout_from_o[INOUT_PIN_SDA0],
       inout_from_o[INOUT_PIN_MB5], inout_from_o[INOUT_PIN_MB6]} == 4'hf)
    else begin
      fail_count++;
      $error("error %0t inout_from_o tie-offs expected 1111 got %b", $time,
             $sampled({inout_from_o[INOUT_PIN_SCL0], inout_from_o[INOUT_PIN_SDA0],
                       inout_from_o[INOUT_PIN_MB5], inout_from_o[INOUT_PIN_MB6]}));
    end

  // Targets are cleared in reset and in the first cycle after it.
  a_loop_reset: assert property (@(posedge clk_i)
      (!rst_ni || !$past(rst_ni)) |-> loop_dst == '0)
    else begin
      fail_count++;
      $error("error %0t loopback targets expected 00000 got %b", $time, $sampled(loop_dst));
    end

  a_loop: assert property (@(posedge clk_i)
      (rst_ni && $past(rst_ni)) |-> loop_dst == loop_src_q)
    else begin
      fail_count++;
      $error("error %0t loopback targets expected %b got %b", $time,
             $sampled(loop_src_q), $sampled(loop_dst));
    end

  a_rs485_rx: assert property (@(posedge clk_i)
      in_pins_o[IN_PIN_RS485_RX] == (rs485_rx_en_i & rs485_line_i))
    else begin
      fail_count++;
      $error("error %0t in_pins_o RS485_RX expected %b got %b", $time,
             $sampled(rs485_rx_en_i & rs485_line_i), $sampled(in_pins_o[IN_PIN_RS485_RX]));
    end

  a_rs485_tx: assert property (@(posedge clk_i)
      rs485_line_o == (!rs485_tx_en_i | out_pins_i[OUT_PIN_RS485_TX]))
    else begin
      fail_count++;
      $error("error %0t rs485_line_o expected %b got %b", $time,
             $sampled(!rs485_tx_en_i | out_pins_i[OUT_PIN_RS485_TX]), $sampled(rs485_line_o));
    end

  a_seen: assert property (@(posedge clk_i) fault_seen_o == seen_ref)
    else begin
      fail_count++;
      $error("error %0t fault_seen_o expected %b got %b", $time,
             $sampled(seen_ref), $sampled(fault_seen_o));
    end

  a_new: assert property (@(posedge clk_i)
      (rst_ni && $past(rst_ni)) |-> new_fault_o == (|fresh_q))
    else begin
      fail_count++;
      $error("error %0t new_fault_o expected %b got %b", $time,
             $sampled(|fresh_q), $sampled(new_fault_o));
    end

  a_first: assert property (@(posedge clk_i)
      (rst_ni && $past(rst_ni) && new_fault_o) |-> (fault_vec_t'(1) << first_fault_o) == lowest_q)
    else begin
      fail_count++;
      $error("error %0t first_fault_o expected one-hot %b got %0d", $time,
             $sampled(lowest_q), $sampled(first_fault_o));
    end

  a_fault_reset: assert property (@(posedge clk_i)
      (!rst_ni || !$past(rst_ni)) |-> (!new_fault_o && first_fault_o == FAULT_BOUNDS))
    else begin
      fail_count++;
      $error("error %0t new_fault_o/first_fault_o after reset expected 0/0 got %b/%0d", $time,
             $sampled(new_fault_o), $sampled(first_fault_o));
    end

endmodule

bind board_harness board_harness_asserts #(
  .NumI2cBuses (NumI2cBuses)
) u_asserts (.*);

// ==== test/board_harness_tb.sv ====
/*
 * Board harness testbench.
 * Random stimulus per behavior, checked by the bound assertions.
 */
`timescale 1ns/10ps

module board_harness_tb import harness_pkg::*; ();

  localparam int unsigned NumBuses   = 3;
  localparam int unsigned TestCycles = 200;
  localparam int unsigned NumTests   = 5;
  // Five tests with resets and report gaps, plus margin.
  localparam int unsigned MaxCycles  = NumTests * TestCycles + 500;

  logic                      clk;
  logic                      rst_n;
  out_pins_t                 out_pins;
  inout_pins_t               inout_to;
  inout_pins_t               inout_en;
  in_pins_t                  in_pins;
  inout_pins_t               inout_from;
  logic                      rs485_tx_en;
  logic                      rs485_rx_en;
  logic                      rs485_line_in;
  logic                      rs485_line_out;
  i2c_lines_t [NumBuses-1:0] i2c_dev;
  i2c_lines_t [NumBuses-1:0] i2c_bus;
  fault_vec_t                cheri_err;
  fault_vec_t                fault_seen;
  logic                      new_fault;
  fault_e                    first_fault;

  logic [31:0] seed;
  int unsigned cycle_count = 0;
  int unsigned tests_run;
  int unsigned tests_failed;

  board_harness #(
    .NumI2cBuses (NumBuses)
  ) dut0 (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .out_pins_i    (out_pins),
    .inout_to_i    (inout_to),
    .inout_en_i    (inout_en),
    .in_pins_o     (in_pins),
    .inout_from_o  (inout_from),
    .rs485_tx_en_i (rs485_tx_en),
    .rs485_rx_en_i (rs485_rx_en),
    .rs485_line_i  (rs485_line_in),
    .rs485_line_o  (rs485_line_out),
    .i2c_dev_i     (i2c_dev),
    .i2c_bus_o     (i2c_bus),
    .cheri_err_i   (cheri_err),
    .fault_seen_o  (fault_seen),
    .new_fault_o   (new_fault),
    .first_fault_o (first_fault)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run limit.
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MaxCycles) begin
      $display("timeout: run did not end within %0d clock cycles", MaxCycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // LCG step with the high half swapped down since the low bits cycle fast.
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return {seed[15:0], seed[31:16]};
  endfunction

  // Holds reset low for four cycles and releases it on a falling edge.
  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // Lets the last checks fire, then reports from the failure count.
  task automatic report_test(input string name, input int unsigned base);
    int unsigned now;
    repeat (2) @(negedge clk);
    now = dut0.u_asserts.fail_count;
    tests_run++;
    if (now == base) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d assertion failures", name, now - base);
    end
  endtask

  task automatic i2c_resolve_test();
    logic [31:0] r;
    int unsigned base;
    base = dut0.u_asserts.fail_count;
    repeat (TestCycles) begin
      @(negedge clk);
      r = next_rand();
      inout_to = r[14:0];
      inout_en = r[29:15];
      r = next_rand();
      i2c_dev = r[2*NumBuses-1:0];
    end
    report_test("i2c_resolve", base);
  endtask

  // Every other cycle all pins are driven low, which the tie-offs must ignore.
  task automatic tie_off_test();
    logic [31:0] r;
    int unsigned base;
    base = dut0.u_asserts.fail_count;
    for (int i = 0; i < TestCycles; i++) begin
      @(negedge clk);
      r = next_rand();
      inout_to = (i % 2 == 0) ? '0 : r[14:0];
      inout_en = (i % 2 == 0) ? '1 : r[29:15];
      i2c_dev  = (i % 2 == 0) ? '0 : r[31:26];
    end
    report_test("tie_off", base);
  endtask

  task automatic loopback_test();
    logic [31:0] r;
    int unsigned base;
    base = dut0.u_asserts.fail_count;
    for (int i = 0; i < TestCycles; i++) begin
      @(negedge clk);
      if (i == TestCycles / 2) begin
        apply_reset();
      end
      r = next_rand();
      out_pins = r[3:0];
      inout_to = r[18:4];
    end
    report_test("loopback", base);
  endtask

  task automatic rs485_test();
    logic [31:0] r;
    int unsigned base;
    base = dut0.u_asserts.fail_count;
    repeat (TestCycles) begin
      @(negedge clk);
      r = next_rand();
      rs485_tx_en   = r[0];
      rs485_rx_en   = r[1];
      rs485_line_in = r[2];
      out_pins      = r[6:3];
    end
    report_test("rs485", base);
  endtask

  // Sparse vectors with repeats; a reset halfway lets classes be new again.
  task automatic fault_latch_test();
    logic [31:0] r;
    fault_vec_t  prev;
    int unsigned base;
    base = dut0.u_asserts.fail_count;
    prev = '0;
    for (int i = 0; i < TestCycles; i++) begin
      @(negedge clk);
      if (i == TestCycles / 2) begin
        apply_reset();
      end
      r = next_rand();
      if (i % 4 == 3) begin
        cheri_err = prev;
      end else begin
        cheri_err = r[8:0] & r[17:9] & r[26:18];
      end
      prev = cheri_err;
    end
    cheri_err = '0;
    report_test("fault_latch", base);
  endtask

  initial begin
    seed          = 32'd14819;
    rst_n         = 1'b0;
    out_pins      = '0;
    inout_to      = '0;
    inout_en      = '0;
    rs485_tx_en   = 1'b0;
    rs485_rx_en   = 1'b0;
    rs485_line_in = 1'b1;
    i2c_dev       = '1;
    cheri_err     = '0;
    tests_run     = 0;
    tests_failed  = 0;
    apply_reset();

    i2c_resolve_test();
    tie_off_test();
    loopback_test();
    rs485_test();
    fault_latch_test();

    $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
             tests_run, tests_run - tests_failed, tests_failed, dut0.u_asserts.fail_count);
    if (tests_failed == 0 && dut0.u_asserts.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
